// File: common/lsu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store path shared definitions: memory opcodes, widths and
// opcode class helpers.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package lsu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int XLEN   = 32;          // Data and address width.
    localparam int MASK_W = XLEN / 8;    // One enable per byte lane.
    localparam int TAG_W  = 5;           // Destination register index.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,                 // Bubble, passes with no access.
        MEM_LB   = 4'd1,                 // Signed byte load.
        MEM_LH   = 4'd2,                 // Signed halfword load.
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,                 // Unsigned byte load.
        MEM_LHU  = 4'd5,                 // Unsigned halfword load.
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode classes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // True for any of the five loads.
    function automatic logic is_load(mem_op_e op);
        logic res;
        case (op)
            MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU: res = 1'b1;
            default:                                  res = 1'b0;
        endcase
        return res;
    endfunction

    // True for any of the three stores.
    function automatic logic is_store(mem_op_e op);
        logic res;
        case (op)
            MEM_SB, MEM_SH, MEM_SW: res = 1'b1;
            default:                res = 1'b0;
        endcase
        return res;
    endfunction

endpackage

// File: logic/lsu_agu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address unit: effective address, alignment check, byte masks, store
// lane shift and the execute/memory stage register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module lsu_agu #(
    parameter int ADDR_W = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        move,

    input  logic                        in_valid,
    input  lsu_pkg::mem_op_e            in_op,
    input  logic [lsu_pkg::XLEN-1:0]    in_base,
    input  logic [11:0]                 in_offset,
    input  logic [lsu_pkg::XLEN-1:0]    in_wdata,
    input  logic [lsu_pkg::TAG_W-1:0]   in_tag,

    output logic                        ex_valid,
    output lsu_pkg::mem_op_e            ex_op,
    output logic [lsu_pkg::XLEN-1:0]    ex_addr,
    output logic [lsu_pkg::XLEN-1:0]    ex_dmem_addr,
    output logic [lsu_pkg::MASK_W-1:0]  ex_rmask,
    output logic [lsu_pkg::MASK_W-1:0]  ex_wmask,
    output logic [lsu_pkg::XLEN-1:0]    ex_wdata,
    output logic [lsu_pkg::TAG_W-1:0]   ex_tag,
    output logic                        ex_misalign
);

    logic [lsu_pkg::XLEN-1:0]   eff_addr;
    logic [lsu_pkg::MASK_W-1:0] size_mask;
    logic [lsu_pkg::MASK_W-1:0] lane_mask;
    logic [lsu_pkg::MASK_W-1:0] rmask;
    logic [lsu_pkg::MASK_W-1:0] wmask;
    logic [lsu_pkg::XLEN-1:0]   wdata_lane;
    logic                       misalign;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address and mask generation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        eff_addr  = in_base + {{(lsu_pkg::XLEN-12){in_offset[11]}}, in_offset};
        size_mask = '0;
        misalign  = 1'b0;
        case (in_op)
            lsu_pkg::MEM_LB, lsu_pkg::MEM_LBU, lsu_pkg::MEM_SB: begin
                size_mask = 4'b0001;
            end
            lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU, lsu_pkg::MEM_SH: begin
                size_mask = 4'b0011;
                misalign  = eff_addr[0];         // Odd halfword.
            end
            lsu_pkg::MEM_LW, lsu_pkg::MEM_SW: begin
                size_mask = 4'b1111;
                misalign  = |eff_addr[1:0];      // Word off a 4-byte boundary.
            end
            default: begin
                size_mask = '0;                  // MEM_NONE touches nothing.
            end
        endcase

        // A misaligned access is dropped, so it carries no lanes.
        lane_mask  = misalign ? '0 : (size_mask << eff_addr[1:0]);
        rmask      = lsu_pkg::is_load(in_op)  ? lane_mask : '0;
        wmask      = lsu_pkg::is_store(in_op) ? lane_mask : '0;
        wdata_lane = in_wdata << {eff_addr[1:0], 3'b000}; // Into byte lanes.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute/memory stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (move) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            ex_op        <= in_op;
            ex_addr      <= eff_addr;
            ex_dmem_addr <= {eff_addr[lsu_pkg::XLEN-1:2], 2'b00};
            ex_rmask     <= rmask;
            ex_wmask     <= wmask;
            ex_wdata     <= wdata_lane;
            ex_tag       <= in_tag;
            ex_misalign  <= misalign;
        end
    end

endmodule

// File: mem_stage/mem_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-access stage: data memory request gating and the
// memory/writeback stage register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        move,

    input  logic                        ex_valid,
    input  lsu_pkg::mem_op_e            ex_op,
    input  logic [lsu_pkg::XLEN-1:0]    ex_addr,
    input  logic [lsu_pkg::XLEN-1:0]    ex_dmem_addr,
    input  logic [lsu_pkg::MASK_W-1:0]  ex_rmask,
    input  logic [lsu_pkg::MASK_W-1:0]  ex_wmask,
    input  logic [lsu_pkg::XLEN-1:0]    ex_wdata,
    input  logic [lsu_pkg::TAG_W-1:0]   ex_tag,
    input  logic                        ex_misalign,

    output logic                        dmem_req,
    output logic [lsu_pkg::XLEN-1:0]    dmem_addr,
    output logic [lsu_pkg::MASK_W-1:0]  dmem_rmask,
    output logic [lsu_pkg::MASK_W-1:0]  dmem_wmask,
    output logic [lsu_pkg::XLEN-1:0]    dmem_wdata,

    output logic                        wb_valid,
    output lsu_pkg::mem_op_e            wb_op,
    output logic [1:0]                  wb_byte_off,
    output logic [lsu_pkg::TAG_W-1:0]   wb_tag,
    output logic                        wb_misalign
);

    logic issue;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data memory request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A stalled or empty slot must not write twice or clobber rdata.
    assign issue = ex_valid && move;

    always_comb begin
        dmem_req   = issue && ((|ex_rmask) || (|ex_wmask));
        dmem_addr  = ex_dmem_addr;               // Word aligned.
        dmem_rmask = '0;
        dmem_wmask = '0;
        dmem_wdata = '0;
        if (dmem_req) begin
            dmem_rmask = ex_rmask;
            dmem_wmask = ex_wmask;
            dmem_wdata = ex_wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory/writeback stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (move) begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            wb_op       <= ex_op;
            wb_byte_off <= ex_addr[1:0];         // Lane select for the aligner.
            wb_tag      <= ex_tag;
            wb_misalign <= ex_misalign;
        end
    end

endmodule

// File: logic/data_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word-organized data RAM with byte write enables and registered read.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module data_mem #(
    parameter int ADDR_W = 8
) (
    input  logic                        clk,
    input  logic                        req,
    input  logic [lsu_pkg::XLEN-1:0]    addr,
    input  logic [lsu_pkg::MASK_W-1:0]  rmask,
    input  logic [lsu_pkg::MASK_W-1:0]  wmask,
    input  logic [lsu_pkg::XLEN-1:0]    wdata,
    output logic [lsu_pkg::XLEN-1:0]    rdata
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [lsu_pkg::XLEN-1:0] mem [DEPTH];
    logic [ADDR_W-1:0]        word_idx;
    logic                     rd_en;

    // Upper bits drop out here, so the address space wraps.
    assign word_idx = addr[ADDR_W+1:2];
    assign rd_en    = req && (|rmask);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte-enabled write
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (req) begin
            for (int i = 0; i < lsu_pkg::MASK_W; i++) begin
                if (wmask[i]) begin
                    mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registered read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Whole word is returned, the aligner picks the lanes.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[word_idx];              // Held while idle.
        end
    end

endmodule

// File: logic/load_align.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load aligner: lane extraction, sign/zero extension and the output
// result register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module load_align (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        move,

    input  logic                        wb_valid,
    input  lsu_pkg::mem_op_e            wb_op,
    input  logic [1:0]                  wb_byte_off,
    input  logic [lsu_pkg::TAG_W-1:0]   wb_tag,
    input  logic                        wb_misalign,
    input  logic [lsu_pkg::XLEN-1:0]    dmem_rdata,

    output logic                        out_valid,
    output logic [lsu_pkg::XLEN-1:0]    out_rdata,
    output logic [lsu_pkg::TAG_W-1:0]   out_tag,
    output lsu_pkg::mem_op_e            out_op,
    output logic                        out_misalign
);

    logic [lsu_pkg::XLEN-1:0] shifted;
    logic [7:0]               byte_lane;
    logic [15:0]              half_lane;
    logic [lsu_pkg::XLEN-1:0] result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane select and extension
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        // Bring the addressed lane down to bit 0.
        shifted   = dmem_rdata >> {wb_byte_off, 3'b000};
        byte_lane = shifted[7:0];
        half_lane = shifted[15:0];
        result    = '0;

        if (lsu_pkg::is_load(wb_op) && !wb_misalign) begin
            case (wb_op)
                lsu_pkg::MEM_LB: begin
                    result = {{(lsu_pkg::XLEN-8){byte_lane[7]}}, byte_lane};
                end
                lsu_pkg::MEM_LBU: begin
                    result = {{(lsu_pkg::XLEN-8){1'b0}}, byte_lane};
                end
                lsu_pkg::MEM_LH: begin
                    result = {{(lsu_pkg::XLEN-16){half_lane[15]}}, half_lane};
                end
                lsu_pkg::MEM_LHU: begin
                    result = {{(lsu_pkg::XLEN-16){1'b0}}, half_lane};
                end
                lsu_pkg::MEM_LW: begin
                    result = dmem_rdata;          // Word is already aligned.
                end
                default: begin
                    result = '0;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output result register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (move) begin
            out_valid <= wb_valid;
        end
    end

    // Held under back-pressure, so the waiting result stays stable.
    always_ff @(posedge clk) begin
        if (move) begin
            out_rdata    <= result;
            out_tag      <= wb_tag;
            out_op       <= wb_op;
            out_misalign <= wb_misalign;
        end
    end

endmodule

// File: logic/lsu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store path top level: stage wiring and pipeline move control.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module lsu_top #(
    parameter int ADDR_W = 8                     // Word-index bits of the RAM.
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        in_valid,
    output logic                        in_ready,
    input  lsu_pkg::mem_op_e            in_op,
    input  logic [lsu_pkg::XLEN-1:0]    in_base,
    input  logic [11:0]                 in_offset,
    input  logic [lsu_pkg::XLEN-1:0]    in_wdata,
    input  logic [lsu_pkg::TAG_W-1:0]   in_tag,

    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [lsu_pkg::XLEN-1:0]    out_rdata,
    output logic [lsu_pkg::TAG_W-1:0]   out_tag,
    output lsu_pkg::mem_op_e            out_op,
    output logic                        out_misalign
);

    logic                       move;

    logic                       ex_valid;
    lsu_pkg::mem_op_e           ex_op;
    logic [lsu_pkg::XLEN-1:0]   ex_addr;
    logic [lsu_pkg::XLEN-1:0]   ex_dmem_addr;
    logic [lsu_pkg::MASK_W-1:0] ex_rmask;
    logic [lsu_pkg::MASK_W-1:0] ex_wmask;
    logic [lsu_pkg::XLEN-1:0]   ex_wdata;
    logic [lsu_pkg::TAG_W-1:0]  ex_tag;
    logic                       ex_misalign;

    logic                       dmem_req;
    logic [lsu_pkg::XLEN-1:0]   dmem_addr;
    logic [lsu_pkg::MASK_W-1:0] dmem_rmask;
    logic [lsu_pkg::MASK_W-1:0] dmem_wmask;
    logic [lsu_pkg::XLEN-1:0]   dmem_wdata;
    logic [lsu_pkg::XLEN-1:0]   dmem_rdata;

    logic                       wb_valid;
    lsu_pkg::mem_op_e           wb_op;
    logic [1:0]                 wb_byte_off;
    logic [lsu_pkg::TAG_W-1:0]  wb_tag;
    logic                       wb_misalign;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Whole pipeline freezes while a result waits at the output.
    assign move     = out_ready || !out_valid;
    assign in_ready = move;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    lsu_agu #(.ADDR_W(ADDR_W)) u_agu (
        .clk(clk), .rst_n(rst_n), .move(move),
        .in_valid(in_valid), .in_op(in_op), .in_base(in_base),
        .in_offset(in_offset), .in_wdata(in_wdata), .in_tag(in_tag),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_addr(ex_addr),
        .ex_dmem_addr(ex_dmem_addr), .ex_rmask(ex_rmask), .ex_wmask(ex_wmask),
        .ex_wdata(ex_wdata), .ex_tag(ex_tag), .ex_misalign(ex_misalign)
    );

    mem_stage u_mem_stage (
        .clk(clk), .rst_n(rst_n), .move(move),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_addr(ex_addr),
        .ex_dmem_addr(ex_dmem_addr), .ex_rmask(ex_rmask), .ex_wmask(ex_wmask),
        .ex_wdata(ex_wdata), .ex_tag(ex_tag), .ex_misalign(ex_misalign),
        .dmem_req(dmem_req), .dmem_addr(dmem_addr), .dmem_rmask(dmem_rmask),
        .dmem_wmask(dmem_wmask), .dmem_wdata(dmem_wdata),
        .wb_valid(wb_valid), .wb_op(wb_op), .wb_byte_off(wb_byte_off),
        .wb_tag(wb_tag), .wb_misalign(wb_misalign)
    );

    data_mem #(.ADDR_W(ADDR_W)) u_data_mem (
        .clk(clk), .req(dmem_req), .addr(dmem_addr),
        .rmask(dmem_rmask), .wmask(dmem_wmask), .wdata(dmem_wdata),
        .rdata(dmem_rdata)
    );

    load_align u_load_align (
        .clk(clk), .rst_n(rst_n), .move(move),
        .wb_valid(wb_valid), .wb_op(wb_op), .wb_byte_off(wb_byte_off),
        .wb_tag(wb_tag), .wb_misalign(wb_misalign), .dmem_rdata(dmem_rdata),
        .out_valid(out_valid), .out_rdata(out_rdata), .out_tag(out_tag),
        .out_op(out_op), .out_misalign(out_misalign)
    );

endmodule

// File: verif/lsu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store path testbench: xorshift requests, byte memory model,
// random back-pressure and result checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module lsu_tb;

    localparam int ADDR_W     = 6;
    localparam int N_INIT     = 1 << ADDR_W;     // One word store per word.
    localparam int N_RAND     = 400;
    localparam int N_TOTAL    = N_INIT + N_RAND;
    localparam int MAX_CYCLES = N_TOTAL * 8 + 200;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 in_valid;
    logic                 in_ready;
    lsu_pkg::mem_op_e     in_op;
    logic [31:0]          in_base;
    logic [11:0]          in_offset;
    logic [31:0]          in_wdata;
    logic [4:0]           in_tag;
    logic                 out_valid;
    logic                 out_ready;
    logic [31:0]          out_rdata;
    logic [4:0]           out_tag;
    lsu_pkg::mem_op_e     out_op;
    logic                 out_misalign;

    logic [7:0]           model_mem [256];       // 4 << ADDR_W bytes.
    logic [31:0]          exp_data [$];
    logic [4:0]           exp_tag [$];
    lsu_pkg::mem_op_e     exp_op [$];
    logic                 exp_mis [$];
    logic [31:0]          rng_state = 32'd74;
    int                   errors = 0;
    int                   results = 0;
    int                   cycles = 0;
    int                   n_sent = 0;
    logic                 accepted = 1'b0;
    logic                 stalled = 1'b0;
    logic [31:0]          held_data;
    logic [4:0]           held_tag;

    lsu_top #(.ADDR_W(ADDR_W)) DUT (.*);

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random source and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic int op_bytes(lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::MEM_LB, lsu_pkg::MEM_LBU, lsu_pkg::MEM_SB: return 1;
            lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU, lsu_pkg::MEM_SH: return 2;
            lsu_pkg::MEM_LW, lsu_pkg::MEM_SW:                   return 4;
            default:                                            return 0;
        endcase
    endfunction

    // Applies the accepted request to the byte model, queues the result.
    task automatic model_accept();
        logic [31:0] addr;
        logic [31:0] val;
        logic        mis;
        logic        is_st;
        int          nb;
        addr  = in_base + {{20{in_offset[11]}}, in_offset};
        nb    = op_bytes(in_op);
        mis   = (nb == 2 && addr[0]) || (nb == 4 && addr[1:0] != 2'b00);
        is_st = (in_op == lsu_pkg::MEM_SB) || (in_op == lsu_pkg::MEM_SH) ||
                (in_op == lsu_pkg::MEM_SW);
        val   = '0;
        if (!mis) begin
            for (int k = 0; k < nb; k++) begin
                if (is_st) begin
                    model_mem[8'(addr + k)] = in_wdata[8*k +: 8];
                end else begin
                    val[8*k +: 8] = model_mem[8'(addr + k)];
                end
            end
        end
        if (in_op == lsu_pkg::MEM_LB) begin
            val = {{24{val[7]}}, val[7:0]};      // Sign from bit 7.
        end
        if (in_op == lsu_pkg::MEM_LH) begin
            val = {{16{val[15]}}, val[15:0]};
        end
        exp_data.push_back(val);
        exp_tag.push_back(in_tag);
        exp_op.push_back(in_op);
        exp_mis.push_back(mis);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_data(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s data: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_tag(string name, logic [4:0] exp, logic [4:0] act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s tag: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_op(string name, lsu_pkg::mem_op_e exp, lsu_pkg::mem_op_e act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s op: expected %s, actual %s (%0d)",
                     name, exp.name(), act.name(), act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic take_result();
        string name;
        if (exp_data.size() == 0) begin
            errors++;
            $display("Result with tag %0d arrived with no request outstanding", out_tag);
        end else begin
            name = exp_mis[0] ? "misalign" : exp_op[0].name();
            results++;
            check_data(name, exp_data.pop_front(), out_rdata);
            check_tag(name, exp_tag.pop_front(), out_tag);
            check_op(name, exp_op.pop_front(), out_op);
            check_flag({name, " misalign flag"}, exp_mis.pop_front(), out_misalign);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake monitor and timeout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        accepted = 1'b0;
        if (rst_n) begin
            cycles++;
            if (in_valid && in_ready) begin
                model_accept();
                accepted = 1'b1;                 // Seen by the driver at negedge.
            end
            if (stalled) begin
                check_flag("stall out_valid", 1'b1, out_valid);
                check_data("stall hold", held_data, out_rdata);
                check_tag("stall hold", held_tag, out_tag);
            end
            if (out_valid && out_ready) begin
                take_result();
            end
            stalled   = out_valid && !out_ready;
            held_data = out_rdata;
            held_tag  = out_tag;
            if (stalled) begin
                check_flag("stall in_ready", 1'b0, in_ready);
            end
            if (cycles > MAX_CYCLES) begin
                $display("Timeout after %0d cycles, %0d results outstanding",
                         cycles, exp_data.size());
                $display("Results checked: %0d, errors: %0d", results, errors + 1);
                $display("Errors found");
                $finish;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic next_request();
        logic [31:0] r;
        r         = next_rand();
        in_valid  = 1'b1;
        in_tag    = n_sent[4:0];
        in_wdata  = next_rand();
        if (n_sent < N_INIT) begin
            in_op     = lsu_pkg::MEM_SW;         // Fill every word first.
            in_base   = 32'h0000_4000 + n_sent * 4;
            in_offset = '0;
        end else begin
            in_op = lsu_pkg::mem_op_e'(4'(r % 9));
            // Otherwise keep the last address, so a load can follow a store.
            if (r[10:9] != 2'b00) begin
                in_base   = 32'h0000_4000 + r[31:24];
                in_offset = 12'(int'(r[15:11]) - 16);
                if (r[17:16] != 2'b00) begin
                    in_base[1:0]   = 2'b00;
                    in_offset[1:0] = 2'b00;
                end
            end
        end
        n_sent++;
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_op     = lsu_pkg::MEM_NONE;
        in_base   = '0;
        in_offset = '0;
        in_wdata  = '0;
        in_tag    = '0;
        out_ready = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (n_sent < N_TOTAL || in_valid) begin
            @(negedge clk);
            if (accepted || !in_valid) begin
                if (n_sent < N_TOTAL) begin
                    next_request();
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_ready = (n_sent <= N_INIT) || ((next_rand() & 32'd3) != 0);
        end

        while (exp_data.size() != 0) begin       // Drain under back-pressure.
            @(negedge clk);
            out_ready = (next_rand() & 32'd3) != 0;
        end
        @(negedge clk);

        $display("Results checked: %0d, errors: %0d", results, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: all.f
common/lsu_pkg.sv
logic/lsu_agu.sv
mem_stage/mem_stage.sv
logic/data_mem.sv
logic/load_align.sv
logic/lsu_top.sv
verif/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - common/lsu_pkg.sv
  - logic/lsu_agu.sv
  - mem_stage/mem_stage.sv
  - logic/data_mem.sv
  - logic/load_align.sv
  - logic/lsu_top.sv
  - target: simulation
    files:
      - verif/lsu_tb.sv
